/* rtl/cft_isa_pkg.sv */
package cft_isa_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Word and instruction field layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int word_w      = 16;   // Data and instruction width
   localparam int opc_lsb     = 12;   // Opcode lives in ir[15:12]
   localparam int jcond_lsb   = 8;    // JMP condition select in ir[11:8]
   localparam int skp_inv_bit = 4;    // SKP result inversion
   localparam int skp_mask_w  = 4;    // SKP flag mask in ir[3:0]

   // Instruction opcodes, codes 8..15 behave as HLT
   typedef enum logic [3:0] {
      OP_HLT = 4'd0,
      OP_LDA,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_STA,
      OP_SKP,
      OP_JMP
   } opcode_t;

   // Micro-level skip condition codes
   // Low group 0xxx: idle plus IR taps (unused), high group 1xxx: reserved and flags
   typedef enum logic [3:0] {
      COND_IDLE  = 4'b0000,   // Always skip
      COND_NEVER = 4'b1000,   // Reserved input, never skip
      COND_FV    = 4'b1011,
      COND_FL    = 4'b1100,
      COND_FZ    = 4'b1101,
      COND_FN    = 4'b1110,
      COND_SKP   = 4'b1111    // Instruction mask test
   } cond_t;

   // Processor flags
   typedef struct packed {
      logic v;   // Signed overflow
      logic l;   // Link, carry out
      logic z;   // Zero
      logic n;   // Negative
   } flags_t;

   // ALU operations issued by the sequencer
   typedef enum logic [2:0] {
      ALU_NOP,
      ALU_LOAD,
      ALU_ADD,
      ALU_SUB,
      ALU_AND
   } alu_op_t;

endpackage

/* rtl/cft_bus_pkg.sv */
package cft_bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Shared memory bus
   ////////////////////////////////////////////////////////////////////////////

   localparam int addr_w    = 8;                     // Word address width
   localparam int data_w    = cft_isa_pkg::word_w;   // Same as machine word
   localparam int ram_words = 256;                   // Full 8-bit space

   // One master's request, held as a level until granted
   // rd and wr are never both set by a well-behaved master
   typedef struct packed {
      logic              rd;      // Read strobe level
      logic              wr;      // Write strobe level
      logic [addr_w-1:0] addr;    // Word address
      logic [data_w-1:0] wdata;   // Store data, ignored on reads
   } mem_req_t;

   // Width of a full request, handy for the bus monitors
   localparam int req_w = $bits(mem_req_t);

endpackage

/* rtl/skip_unit.sv */
`timescale 1ns/10ps

module skip_unit (
   input  logic                           clk4,
   input  logic                           rst,
   input  cft_isa_pkg::cond_t             cond,
   input  logic [cft_isa_pkg::word_w-1:0] ir,
   input  cft_isa_pkg::flags_t            flags,
   output logic                           nskip
);
   import cft_isa_pkg::*;

   logic [3:0]            cond_bits;    // Raw condition code
   logic [skp_mask_w-1:0] flag_vec;     // Flags in mask bit order
   logic                  mask_hit;     // Any selected flag set
   logic                  branch_hit;   // SKP test after inversion
   logic                  skip_lo;      // Low mux group, codes 0xxx
   logic                  skip_hi;      // High mux group, codes 1xxx
   logic                  skip;         // Selected skip decision, active high

   assign cond_bits = cond;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction flag test
   ////////////////////////////////////////////////////////////////////////////

   // Mask bit 0 tests v, bit 3 tests n
   assign flag_vec   = {flags.n, flags.z, flags.l, flags.v};
   assign mask_hit   = |(flag_vec & ir[skp_mask_w-1:0]);
   assign branch_hit = mask_hit ^ ir[skp_inv_bit];   // Optional negation

   ////////////////////////////////////////////////////////////////////////////
   // Condition multiplexing, two groups of eight
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (cond_bits[2:0])
         3'b000:  skip_lo = 1'b1;   // Idle, always true
         default: skip_lo = 1'b0;   // IR taps not used here
      endcase
   end

   always_comb begin
      case (cond_bits[2:0])
         3'b011:  skip_hi = flags.v;
         3'b100:  skip_hi = flags.l;
         3'b101:  skip_hi = flags.z;
         3'b110:  skip_hi = flags.n;
         3'b111:  skip_hi = branch_hit;   // SKP instruction logic
         default: skip_hi = 1'b0;         // Reserved inputs read as never
      endcase
   end

   assign skip = cond_bits[3] ? skip_hi : skip_lo;

   // Hold the decision for the next micro-step
   always_ff @(posedge clk4) begin
      if (rst) begin
         nskip <= 1'b1;        // No skip pending out of reset
      end else begin
         nskip <= ~skip;       // Active low
      end
   end

endmodule

/* rtl/alu_flags.sv */
`timescale 1ns/10ps

module alu_flags (
   input  logic                           clk4,
   input  logic                           rst,
   input  cft_isa_pkg::alu_op_t           op,
   input  logic [cft_isa_pkg::word_w-1:0] operand,
   output logic [cft_isa_pkg::word_w-1:0] acc,
   output cft_isa_pkg::flags_t            flags
);
   import cft_isa_pkg::*;

   logic [word_w:0]   sum;          // Extra bit holds carry out
   logic [word_w-1:0] result;       // Next accumulator value
   flags_t            flags_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // Result and flag logic
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      sum       = '0;
      result    = acc;
      flags_nxt = flags;
      case (op)
         ALU_LOAD: begin
            result = operand;
         end
         ALU_ADD: begin
            sum         = {1'b0, acc} + {1'b0, operand};
            result      = sum[word_w-1:0];
            flags_nxt.l = sum[word_w];
            // Same-sign inputs, different-sign result
            flags_nxt.v = (acc[word_w-1] == operand[word_w-1]) &&
                          (result[word_w-1] != acc[word_w-1]);
         end
         ALU_SUB: begin
            // acc + ~operand + 1, carry out is the inverted borrow
            sum         = {1'b0, acc} + {1'b0, ~operand} + 1'b1;
            result      = sum[word_w-1:0];
            flags_nxt.l = sum[word_w];
            flags_nxt.v = (acc[word_w-1] != operand[word_w-1]) &&
                          (result[word_w-1] != acc[word_w-1]);
         end
         ALU_AND: begin
            result      = acc & operand;
            flags_nxt.v = 1'b0;            // l kept
         end
         default: ;                        // NOP holds everything
      endcase
      if (op != ALU_NOP) begin
         flags_nxt.z = (result == '0);
         flags_nxt.n = result[word_w-1];
      end
   end

   always_ff @(posedge clk4) begin
      if (rst) begin
         acc   <= '0;
         flags <= '0;
      end else if (op != ALU_NOP) begin
         acc   <= result;
         flags <= flags_nxt;
      end
   end

endmodule

/* rtl/micro_sequencer.sv */
`timescale 1ns/10ps

module micro_sequencer (
   input  logic                           clk4,
   input  logic                           rst,
   input  logic                           run,
   input  logic                           nskip,
   input  logic [cft_isa_pkg::word_w-1:0] acc,
   input  logic [cft_isa_pkg::word_w-1:0] mem_rdata,
   input  logic                           mem_gnt,
   output cft_bus_pkg::mem_req_t          mem_req,
   output logic [cft_isa_pkg::word_w-1:0] ir,
   output cft_isa_pkg::cond_t             cond,
   output cft_isa_pkg::alu_op_t           alu_op,
   output logic                           halted
);
   import cft_isa_pkg::*;
   import cft_bus_pkg::*;

   typedef enum logic [3:0] {
      S_IDLE,
      S_FETCH,    // Read at pc, wait for grant
      S_LOADIR,   // Capture instruction, pc + 1
      S_DECODE,
      S_READ,     // Operand read, wait for grant
      S_EXEC,     // ALU op on returned data
      S_WRITE,    // Store acc, wait for grant
      S_TEST,     // Present condition to skip unit
      S_APPLY,    // Use registered nskip
      S_HALTED
   } seq_state_t;

   seq_state_t        state;
   seq_state_t        state_nxt;
   logic [addr_w-1:0] pc;
   opcode_t           opc;
   logic [3:0]        jcond;   // JMP condition select

   assign opc    = opcode_t'(ir[opc_lsb +: 4]);
   assign jcond  = ir[jcond_lsb +: 4];
   assign halted = (state == S_HALTED);

   ////////////////////////////////////////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE:   if (run) state_nxt = S_FETCH;
         S_FETCH:  if (mem_gnt) state_nxt = S_LOADIR;
         S_LOADIR: state_nxt = S_DECODE;
         S_DECODE: begin
            case (opc)
               OP_LDA, OP_ADD, OP_SUB, OP_AND: state_nxt = S_READ;
               OP_STA:                         state_nxt = S_WRITE;
               OP_SKP, OP_JMP:                 state_nxt = S_TEST;
               default:                        state_nxt = S_HALTED;   // HLT and undefined
            endcase
         end
         S_READ:   if (mem_gnt) state_nxt = S_EXEC;
         S_EXEC:   state_nxt = S_FETCH;
         S_WRITE:  if (mem_gnt) state_nxt = S_FETCH;
         S_TEST:   state_nxt = S_APPLY;
         S_APPLY:  state_nxt = S_FETCH;
         S_HALTED: if (!run) state_nxt = S_IDLE;
         default:  state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk4) begin
      if (rst) begin
         state <= S_IDLE;
         pc    <= '0;
      end else begin
         state <= state_nxt;
         if (state == S_LOADIR) begin
            pc <= pc + 1'b1;
         end
         if (state == S_APPLY && !nskip) begin
            if (opc == OP_JMP) begin
               pc <= ir[addr_w-1:0];   // Branch taken
            end else begin
               pc <= pc + 1'b1;        // SKP hops one word
            end
         end
      end
   end

   // Instruction register, loaded from the word returned after the fetch grant
   always_ff @(posedge clk4) begin
      if (state == S_LOADIR) begin
         ir <= mem_rdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus request, condition code and ALU op
   ////////////////////////////////////////////////////////////////////////////

   // Derived from state and held registers only, so a waiting request stays put
   always_comb begin
      mem_req = '0;
      case (state)
         S_FETCH: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = pc;
         end
         S_READ: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = ir[addr_w-1:0];
         end
         S_WRITE: begin
            mem_req.wr    = 1'b1;
            mem_req.addr  = ir[addr_w-1:0];
            mem_req.wdata = acc;
         end
         default: ;
      endcase
   end

   always_comb begin
      cond = COND_IDLE;   // Idle micro-code between tests
      if (state == S_TEST) begin
         if (opc == OP_SKP) begin
            cond = COND_SKP;
         end else begin
            case (jcond)
               4'd0:    cond = COND_IDLE;    // Unconditional
               4'd1:    cond = COND_FV;
               4'd2:    cond = COND_FL;
               4'd3:    cond = COND_FZ;
               4'd4:    cond = COND_FN;
               default: cond = COND_NEVER;
            endcase
         end
      end
   end

   always_comb begin
      alu_op = ALU_NOP;
      if (state == S_EXEC) begin
         case (opc)
            OP_LDA:  alu_op = ALU_LOAD;
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            default: alu_op = ALU_NOP;
         endcase
      end
   end

endmodule

/* rtl/shared_ram.sv */
`timescale 1ns/10ps

module shared_ram (
   input  logic                           clk4,
   input  logic                           rst,
   input  cft_bus_pkg::mem_req_t          host_req,
   input  cft_bus_pkg::mem_req_t          core_req,
   output logic [cft_bus_pkg::data_w-1:0] host_rdata,
   output logic [cft_bus_pkg::data_w-1:0] core_rdata,
   output logic                           core_gnt
);
   import cft_bus_pkg::*;

   logic [data_w-1:0] mem [ram_words];   // Single-port array

   logic              host_act;    // Host owns the port this cycle
   logic              core_act;    // Core asking
   mem_req_t          sel_req;     // Winning request
   logic [data_w-1:0] rd_word;     // Array read at the winning address

   ////////////////////////////////////////////////////////////////////////////
   // Fixed-priority arbiter, host first
   ////////////////////////////////////////////////////////////////////////////

   assign host_act = host_req.rd | host_req.wr;
   assign core_act = core_req.rd | core_req.wr;
   assign core_gnt = core_act & ~host_act;   // Core waits out any host cycle

   assign sel_req = host_act ? host_req : core_req;
   assign rd_word = mem[sel_req.addr];

   // Writes land at the granted edge, none while in reset
   always_ff @(posedge clk4) begin
      if (!rst && sel_req.wr) begin
         mem[sel_req.addr] <= sel_req.wdata;
      end
   end

   // Read data is back the cycle after the grant, one register per master
   always_ff @(posedge clk4) begin
      if (host_req.rd) begin
         host_rdata <= rd_word;
      end
      if (core_gnt && core_req.rd) begin
         core_rdata <= rd_word;
      end
   end

endmodule

/* rtl/cft_core.sv */
`timescale 1ns/10ps

module cft_core (
   input  logic                           clk4,
   input  logic                           rst,
   input  logic                           run,
   input  cft_bus_pkg::mem_req_t          host_req,
   output logic [cft_bus_pkg::data_w-1:0] host_rdata,
   output logic                           halted,
   output cft_isa_pkg::flags_t            flags
);
   import cft_isa_pkg::*;
   import cft_bus_pkg::*;

   mem_req_t          core_req;     // Sequencer side of the bus
   logic [data_w-1:0] core_rdata;
   logic              core_gnt;
   logic [word_w-1:0] ir;
   logic [word_w-1:0] acc;          // Also the store data
   cond_t             cond;
   alu_op_t           alu_op;
   logic              nskip;        // Registered skip decision

   ////////////////////////////////////////////////////////////////////////////
   // Datapath and control
   ////////////////////////////////////////////////////////////////////////////

   micro_sequencer u_seq (
      .clk4      (clk4),
      .rst       (rst),
      .run       (run),
      .nskip     (nskip),
      .acc       (acc),
      .mem_rdata (core_rdata),
      .mem_gnt   (core_gnt),
      .mem_req   (core_req),
      .ir        (ir),
      .cond      (cond),
      .alu_op    (alu_op),
      .halted    (halted)
   );

   // Operand comes straight from the core read register
   alu_flags u_alu (
      .clk4    (clk4),
      .rst     (rst),
      .op      (alu_op),
      .operand (core_rdata),
      .acc     (acc),
      .flags   (flags)
   );

   skip_unit u_sbu (
      .clk4  (clk4),
      .rst   (rst),
      .cond  (cond),
      .ir    (ir),
      .flags (flags),
      .nskip (nskip)
   );

   shared_ram u_ram (
      .clk4       (clk4),
      .rst        (rst),
      .host_req   (host_req),
      .core_req   (core_req),
      .host_rdata (host_rdata),
      .core_rdata (core_rdata),
      .core_gnt   (core_gnt)
   );

endmodule

/* sim/skip_unit_checker.sv */
`timescale 1ns/10ps

module skip_unit_checker (
   input logic                clk4,
   input logic                rst,
   input cft_isa_pkg::cond_t  cond,
   input cft_isa_pkg::flags_t flags,
   input logic                nskip
);
   import cft_isa_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Skip register properties
   ////////////////////////////////////////////////////////////////////////////

   // Reset clears any pending skip
   a_reset_high: assert property (@(posedge clk4) rst |=> nskip)
      else $error("nskip not high after reset");

   a_idle_skips: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_IDLE |=> !nskip)
      else $error("idle condition did not skip");

   a_never_holds: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_NEVER |=> nskip)
      else $error("reserved condition skipped");

   // Flag tests, decision follows the flag one cycle later
   a_flag_v: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_FV |=> nskip == !$past(flags.v))
      else $error("v condition mismatch");

   a_flag_l: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_FL |=> nskip == !$past(flags.l))
      else $error("l condition mismatch");

   a_flag_z: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_FZ |=> nskip == !$past(flags.z))
      else $error("z condition mismatch");

   a_flag_n: assert property (@(posedge clk4) disable iff (rst)
      cond == COND_FN |=> nskip == !$past(flags.n))
      else $error("n condition mismatch");

endmodule

bind skip_unit skip_unit_checker u_skip_chk (
   .clk4  (clk4),
   .rst   (rst),
   .cond  (cond),
   .flags (flags),
   .nskip (nskip)
);

/* sim/cft_core_tb.sv */
`timescale 1ns/10ps

module cft_core_tb;
   import cft_isa_pkg::*;
   import cft_bus_pkg::*;

   logic              clk4 = 1'b0;
   logic              rst;
   logic              run;
   mem_req_t          host_req;
   logic [data_w-1:0] host_rdata;
   logic              halted;
   flags_t            flags;

   logic [word_w-1:0] ref_mem [ram_words];   // Model memory holding image and then results
   logic [addr_w-1:0] code_ptr;              // Next program word
   logic [31:0]       lfsr = 32'h951b;
   int unsigned       budget = 100;          // Watchdog cycle allowance
   logic              rd_pend = 1'b0;        // Host read issued last cycle
   logic [addr_w-1:0] rd_addr;

   always #5 clk4 = ~clk4;

   cft_core u_cft_core (
      .clk4       (clk4),
      .rst        (rst),
      .run        (run),
      .host_req   (host_req),
      .host_rdata (host_rdata),
      .halted     (halted),
      .flags      (flags)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Failure handling and compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_word(input string name, input logic [word_w-1:0] got,
                             input logic [word_w-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_flags(input string name, input flags_t got, input flags_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [word_w-1:0] encode(input opcode_t op, input logic [11:0] fld);
      return {op, fld};
   endfunction

   task automatic emit(input logic [word_w-1:0] w);
      ref_mem[code_ptr] = w;
      code_ptr++;
   endtask

   task automatic host_cycle(input logic rd, input logic wr, input logic [addr_w-1:0] addr,
                             input logic [word_w-1:0] wdata);
      @(negedge clk4);
      host_req.rd    = rd;
      host_req.wr    = wr;
      host_req.addr  = addr;
      host_req.wdata = wdata;
   endtask

   task automatic apply_reset();
      @(negedge clk4);
      rst      = 1'b1;
      run      = 1'b0;
      host_req = '0;
      repeat (8) @(negedge clk4);
      rst = 1'b0;
   endtask

   task automatic load_memory();
      for (int a = 0; a < ram_words; a++) begin
         host_cycle(1'b0, 1'b1, 8'(a), ref_mem[a]);
      end
      host_cycle(1'b0, 1'b0, '0, '0);
   endtask

   // Read back every word of the RAM
   task automatic read_all();
      for (int a = 0; a < ram_words; a++) begin
         host_cycle(1'b1, 1'b0, 8'(a), '0);
      end
      host_cycle(1'b0, 1'b0, '0, '0);
      @(negedge clk4);                    // Last compare done before model changes
   endtask

   // Host traffic with random idle gaps so the core stalls in several states
   task automatic host_burst();
      logic [word_w-1:0] d;
      int                gap;
      for (int i = 0; i < 8; i++) begin
         d = 16'(next_bits(16));
         host_cycle(1'b0, 1'b1, 8'hf0 + 8'(i), d);
         ref_mem[8'hf0 + i] = d;           // Scratch area the program never touches
         host_cycle(1'b1, 1'b0, 8'hf0 + 8'(i), '0);
         gap = int'(next_bits(2));
         for (int g = 0; g < gap; g++) begin
            host_cycle(1'b0, 1'b0, '0, '0);   // Core may use the bus here
         end
      end
      host_cycle(1'b0, 1'b0, '0, '0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Programs and reference model
   ////////////////////////////////////////////////////////////////////////////

   // Kind 0 is random ALU ops and stores
   // Kind 1 adds SKP with markers and kind 2 adds JMP over every code
   task automatic build_program(input int kind);
      opcode_t op;
      for (int a = 0; a < ram_words; a++) begin
         ref_mem[a] = {8'(a) ^ 8'h3c, ~8'(a)};
      end
      for (int i = 0; i < 16; i++) begin
         ref_mem[8'h80 + i] = 16'(next_bits(16));   // Data at 0x80
      end
      ref_mem[8'h8e] = 16'h8000;          // Overflow source
      ref_mem[8'h8f] = '0;                // Zero source
      code_ptr = '0;
      emit(encode(OP_LDA, 12'h080));
      for (int i = 0; i < 16; i++) begin
         if (kind == 0) begin
            op = opcode_t'(4'(next_bits(3) % 5) + 4'd1);   // LDA..STA
         end else begin
            op = opcode_t'(4'(next_bits(2)) + 4'd1);        // LDA..AND
         end
         if (op == OP_STA) begin
            emit(encode(OP_STA, {4'h0, 8'ha0 + 8'(next_bits(4))}));
         end else begin
            emit(encode(op, {4'h0, 8'h80 + 8'(next_bits(4))}));
         end
         if (kind == 1) begin
            emit(encode(OP_SKP, {7'h00, 5'(next_bits(5))}));   // Mask and invert
            emit(encode(OP_STA, {4'h0, 8'hb0 + 8'(i)}));      // Marker
         end else if (kind == 2) begin
            emit(encode(OP_JMP, {4'(i), code_ptr + 8'd2}));   // Hops the marker
            emit(encode(OP_STA, {4'h0, 8'hb0 + 8'(i)}));
         end
      end
      emit(encode(OP_HLT, 12'h000));
   endtask

   // Runs the instruction set on ref_mem and returns the final flags
   function automatic flags_t run_reference(output int steps);
      logic [addr_w-1:0] pc;
      logic [word_w-1:0] acc;
      logic [word_w-1:0] ir;
      logic [word_w-1:0] opd;
      logic              go;
      logic              done;
      int                sres;    // Signed result before wrap
      flags_t            f;
      pc    = '0;
      acc   = '0;
      f     = '0;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 1000) begin
         ir  = ref_mem[pc];
         opd = ref_mem[ir[7:0]];
         pc  = pc + 8'd1;
         steps++;
         case (opcode_t'(ir[15:12]))
            OP_LDA: acc = opd;
            OP_ADD: begin
               sres = int'($signed(acc)) + int'($signed(opd));
               f.l  = (int'(acc) + int'(opd)) > 65535;    // Carry out
               f.v  = (sres > 32767) || (sres < -32768);
               acc  = acc + opd;
            end
            OP_SUB: begin
               sres = int'($signed(acc)) - int'($signed(opd));
               f.l  = (acc >= opd);                        // No borrow
               f.v  = (sres > 32767) || (sres < -32768);
               acc  = acc - opd;
            end
            OP_AND: begin
               acc = acc & opd;
               f.v = 1'b0;
            end
            OP_STA: ref_mem[ir[7:0]] = acc;
            OP_SKP: begin
               go = (|({f.n, f.z, f.l, f.v} & ir[3:0])) ^ ir[4];
               if (go) pc = pc + 8'd1;
            end
            OP_JMP: begin
               case (ir[11:8])
                  4'd0:    go = 1'b1;
                  4'd1:    go = f.v;
                  4'd2:    go = f.l;
                  4'd3:    go = f.z;
                  4'd4:    go = f.n;
                  default: go = 1'b0;   // Never codes
               endcase
               if (go) pc = ir[7:0];
            end
            default: done = 1'b1;         // HLT and undefined codes
         endcase
         if (ir[15:12] inside {OP_LDA, OP_ADD, OP_SUB, OP_AND}) begin
            f.z = (acc == '0);
            f.n = acc[word_w-1];
         end
      end
      return f;
   endfunction

   task automatic run_program(input logic with_host);
      flags_t exp_flags;
      int     steps;
      budget += 1000;                     // Reset, load, readbacks and host traffic
      apply_reset();
      check_bit("halted", halted, 1'b0);
      load_memory();
      repeat (20) @(negedge clk4);
      check_bit("halted", halted, 1'b0);
      read_all();                         // Image untouched while run is low
      exp_flags = run_reference(steps);
      budget += 60 * steps;
      @(negedge clk4);
      run = 1'b1;
      if (with_host) begin
         host_burst();
      end
      while (!halted) @(negedge clk4);
      check_flags("flags", flags, exp_flags);
      read_all();
      @(negedge clk4);
      run = 1'b0;
      @(negedge clk4);
      check_bit("halted", halted, 1'b0);  // Back to IDLE
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare process, watchdog and main sequence
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk4) begin
      rd_pend <= host_req.rd;
      rd_addr <= host_req.addr;
   end

   // Read data valid one cycle after the request
   always @(negedge clk4) begin
      if (rd_pend) begin
         check_word($sformatf("host_rdata[%h]", rd_addr), host_rdata, ref_mem[rd_addr]);
      end
   end

   initial begin : watchdog
      int unsigned cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < budget) begin
         @(posedge clk4);
         cycle_cnt++;
      end
      abort_run("Watchdog expired, a program did not reach halt in its cycle budget");
   end

   initial begin
      rst      = 1'b1;
      run      = 1'b0;
      host_req = '0;
      build_program(0);
      run_program(1'b0);                  // Random ALU program
      build_program(1);
      run_program(1'b0);                  // SKP markers
      build_program(2);
      run_program(1'b0);                  // JMP on all 16 codes
      build_program(0);
      run_program(1'b1);                  // Host traffic against a running core
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* flist.f */
rtl/cft_isa_pkg.sv
rtl/cft_bus_pkg.sv
rtl/skip_unit.sv
rtl/alu_flags.sv
rtl/micro_sequencer.sv
rtl/shared_ram.sv
rtl/cft_core.sv
sim/skip_unit_checker.sv
sim/cft_core_tb.sv

/* Makefile */
TOP := cft_core_tb

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f flist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q "TESTS FAILED" sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
